// File: hdl/dallanma_birimi.sv
`timescale 1ns/1ps
`default_nettype none

module dallanma_birimi (
    input  logic [dallanma_pkg::UOP_DAL_BIT-1:0] islem_kod_i,
    input  logic [dallanma_pkg::PS_BIT-1:0]      islem_ps_i,
    input  logic [dallanma_pkg::PS_BIT-1:0]      islem_islec_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_anlik_i,
    input  logic                                islem_atladi_i,

    input  logic                                amb_esittir_i,
    input  logic                                amb_kucuktur_i,
    input  logic                                amb_kucuktur_isaretsiz_i,

    output logic [dallanma_pkg::PS_BIT-1:0]      g1_ps_o,
    output logic                                g1_ps_gecerli_o,

    output logic [dallanma_pkg::PS_BIT-1:0]      g2_ps_o,
    output logic                                g2_guncelle_o,
    output logic                                g2_atladi_o,
    output logic                                g2_hatali_tahmin_o,

    output logic [dallanma_pkg::PS_BIT-1:0]      ps_atlamadi_o
);

    dallanma_pkg::dal_kod_t              kod;
    logic                                dal_gecerli;   // Code is one of the ten
    logic                                atlama;        // Unconditional jump
    logic                                kisa;          // Compressed form
    logic                                atladi;
    logic [dallanma_pkg::PS_BIT-1:0]     adim;
    logic [dallanma_pkg::PS_BIT-1:0]     ps_atladi;
    logic [dallanma_pkg::PS_BIT-1:0]     ps_atlamadi;

    assign kod = dallanma_pkg::dal_kod_t'(islem_kod_i);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Direction and targets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        dal_gecerli = 1'b1;
        atlama      = 1'b0;
        kisa        = 1'b0;
        atladi      = 1'b0;
        ps_atladi   = islem_islec_i + islem_anlik_i;

        case (kod)
            dallanma_pkg::UOP_DAL_BEQ: begin
                atladi = amb_esittir_i;
            end
            dallanma_pkg::UOP_DAL_BNE: begin
                atladi = !amb_esittir_i;
            end
            dallanma_pkg::UOP_DAL_BLT: begin
                atladi = amb_kucuktur_i;
            end
            dallanma_pkg::UOP_DAL_BGE: begin
                atladi = !amb_kucuktur_i;
            end
            dallanma_pkg::UOP_DAL_BLTU: begin
                atladi = amb_kucuktur_isaretsiz_i;
            end
            dallanma_pkg::UOP_DAL_BGEU: begin
                atladi = !amb_kucuktur_isaretsiz_i;
            end
            dallanma_pkg::UOP_DAL_JAL: begin
                atlama = 1'b1;
            end
            dallanma_pkg::UOP_DAL_CJAL: begin
                atlama = 1'b1;
                kisa   = 1'b1;
            end
            dallanma_pkg::UOP_DAL_JALR: begin
                atlama       = 1'b1;
                ps_atladi[0] = 1'b0;    // Register targets are halfword aligned
            end
            dallanma_pkg::UOP_DAL_CJALR: begin
                atlama       = 1'b1;
                kisa         = 1'b1;
                ps_atladi[0] = 1'b0;
            end
            default: begin
                dal_gecerli = 1'b0;
            end
        endcase

        if (atlama) begin
            atladi = 1'b1;
        end
    end

    // Fall-through step is 2 for compressed, else 4
    always_comb begin
        adim      = '0;
        adim[2:1] = kisa ? 2'b01 : 2'b10;
    end

    assign ps_atlamadi = islem_ps_i + adim;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign g2_guncelle_o      = dal_gecerli;
    assign g2_ps_o            = dal_gecerli ? islem_ps_i : '0;
    assign g2_atladi_o        = dal_gecerli & atladi;
    assign g2_hatali_tahmin_o = dal_gecerli & (atladi != islem_atladi_i);

    // Redirect only on a wrong guess
    assign g1_ps_gecerli_o = g2_hatali_tahmin_o;
    assign g1_ps_o         = !dal_gecerli ? '0 : (atladi ? ps_atladi : ps_atlamadi);

    assign ps_atlamadi_o = ps_atlamadi;  // Link address

endmodule

`default_nettype wire

// File: hdl/dallanma_pkg.sv
`default_nettype none

package dallanma_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PS_BIT      = 32;    // Program counter
    localparam int VERI_BIT    = 32;    // Operands and immediate
    localparam int UOP_DAL_BIT = 4;     // Branch micro-op code

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch micro-operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Codes 10 to 15 are non-branch and leave the table alone
    typedef enum logic [UOP_DAL_BIT-1:0] {
        UOP_DAL_BEQ   = 4'd0,
        UOP_DAL_BNE   = 4'd1,
        UOP_DAL_BLT   = 4'd2,
        UOP_DAL_BGE   = 4'd3,
        UOP_DAL_BLTU  = 4'd4,
        UOP_DAL_BGEU  = 4'd5,
        UOP_DAL_JAL   = 4'd6,
        UOP_DAL_JALR  = 4'd7,
        UOP_DAL_CJAL  = 4'd8,   // Compressed, falls through to ps+2
        UOP_DAL_CJALR = 4'd9    // Compressed, falls through to ps+2
    } dal_kod_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Direction table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Indexed by ps[TABLO_IDX_BIT:1]
    localparam int TABLO_IDX_BIT = 4;
    localparam int TABLO_BOYUT   = 2 ** TABLO_IDX_BIT;

    // Weakly not taken
    localparam logic [1:0] SAYAC_BASLANGIC = 2'd1;

endpackage

`default_nettype wire

// File: hdl/dallanma_ust.sv
`timescale 1ns/1ps
`default_nettype none

module dallanma_ust (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  logic                                islem_req_i,
    input  logic [dallanma_pkg::UOP_DAL_BIT-1:0] islem_kod_i,
    input  logic [dallanma_pkg::PS_BIT-1:0]      islem_ps_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_kaynak1_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_kaynak2_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_anlik_i,

    output logic                                islem_ack_o,
    output logic [dallanma_pkg::PS_BIT-1:0]      hedef_ps_o,
    output logic                                yonlendir_o,
    output logic                                hatali_tahmin_o,
    output logic                                atladi_o,
    output logic                                tahmin_o,
    output logic [dallanma_pkg::PS_BIT-1:0]      donus_ps_o,
    output logic                                guncelle_o
);

    logic                                 sonuc_yaz;
    logic [dallanma_pkg::UOP_DAL_BIT-1:0] kod;
    logic [dallanma_pkg::PS_BIT-1:0]      ps;
    logic [dallanma_pkg::VERI_BIT-1:0]    kaynak1;
    logic [dallanma_pkg::VERI_BIT-1:0]    kaynak2;
    logic [dallanma_pkg::VERI_BIT-1:0]    anlik;
    logic [dallanma_pkg::PS_BIT-1:0]      islec;

    logic esittir;
    logic kucuktur;
    logic kucuktur_isaretsiz;
    logic tahmin;

    logic [dallanma_pkg::PS_BIT-1:0] g1_ps;
    logic                            g1_ps_gecerli;
    logic [dallanma_pkg::PS_BIT-1:0] g2_ps;
    logic                            g2_guncelle;
    logic                            g2_atladi;
    logic                            g2_hatali_tahmin;
    logic [dallanma_pkg::PS_BIT-1:0] ps_atlamadi;

    islem_girisi u_giris (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .islem_req_i     (islem_req_i),
        .islem_kod_i     (islem_kod_i),
        .islem_ps_i      (islem_ps_i),
        .islem_kaynak1_i (islem_kaynak1_i),
        .islem_kaynak2_i (islem_kaynak2_i),
        .islem_anlik_i   (islem_anlik_i),
        .islem_ack_o     (islem_ack_o),
        .sonuc_yaz_o     (sonuc_yaz),
        .kod_o           (kod),
        .ps_o            (ps),
        .kaynak1_o       (kaynak1),
        .kaynak2_o       (kaynak2),
        .anlik_o         (anlik)
    );

    karsilastirici u_karsilastirici (
        .kaynak1_i            (kaynak1),
        .kaynak2_i            (kaynak2),
        .esittir_o            (esittir),
        .kucuktur_o           (kucuktur),
        .kucuktur_isaretsiz_o (kucuktur_isaretsiz)
    );

    // Training lands on the same edge as the result registers
    tahmin_tablosu u_tablo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .oku_ps_i   (ps),
        .tahmin_o   (tahmin),
        .guncelle_i (sonuc_yaz & g2_guncelle),
        .yaz_ps_i   (g2_ps),
        .atladi_i   (g2_atladi)
    );

    // Register-relative jumps use rs1 as base, all others the pc
    assign islec = (kod == dallanma_pkg::UOP_DAL_JALR || kod == dallanma_pkg::UOP_DAL_CJALR)
                   ? kaynak1 : ps;

    dallanma_birimi u_dallanma (
        .islem_kod_i              (kod),
        .islem_ps_i               (ps),
        .islem_islec_i            (islec),
        .islem_anlik_i            (anlik),
        .islem_atladi_i           (tahmin),
        .amb_esittir_i            (esittir),
        .amb_kucuktur_i           (kucuktur),
        .amb_kucuktur_isaretsiz_i (kucuktur_isaretsiz),
        .g1_ps_o                  (g1_ps),
        .g1_ps_gecerli_o          (g1_ps_gecerli),
        .g2_ps_o                  (g2_ps),
        .g2_guncelle_o            (g2_guncelle),
        .g2_atladi_o              (g2_atladi),
        .g2_hatali_tahmin_o       (g2_hatali_tahmin),
        .ps_atlamadi_o            (ps_atlamadi)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            yonlendir_o     <= 1'b0;
            hatali_tahmin_o <= 1'b0;
            atladi_o        <= 1'b0;
            guncelle_o      <= 1'b0;
        end else if (sonuc_yaz) begin
            yonlendir_o     <= g1_ps_gecerli;
            hatali_tahmin_o <= g2_hatali_tahmin;
            atladi_o        <= g2_atladi;
            guncelle_o      <= g2_guncelle;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sonuc_yaz) begin
            hedef_ps_o <= g1_ps;
            donus_ps_o <= ps_atlamadi;
            tahmin_o   <= tahmin;   // Counter state before this training
        end
    end

endmodule

`default_nettype wire

// File: hdl/islem_girisi.sv
`timescale 1ns/1ps
`default_nettype none

module islem_girisi (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  logic                                islem_req_i,
    input  logic [dallanma_pkg::UOP_DAL_BIT-1:0] islem_kod_i,
    input  logic [dallanma_pkg::PS_BIT-1:0]      islem_ps_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_kaynak1_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_kaynak2_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0]    islem_anlik_i,

    output logic                                islem_ack_o,
    output logic                                sonuc_yaz_o,
    output logic [dallanma_pkg::UOP_DAL_BIT-1:0] kod_o,
    output logic [dallanma_pkg::PS_BIT-1:0]      ps_o,
    output logic [dallanma_pkg::VERI_BIT-1:0]    kaynak1_o,
    output logic [dallanma_pkg::VERI_BIT-1:0]    kaynak2_o,
    output logic [dallanma_pkg::VERI_BIT-1:0]    anlik_o
);

    typedef enum logic [1:0] {
        BOSTA,  // Waiting for req
        COZ,    // Resolve and write results
        ONAY    // Ack held until req drops
    } durum_t;

    durum_t durum;
    durum_t durum_sonraki;
    logic   yakala;

    dallanma_pkg::dal_kod_t                kod_q;
    logic [dallanma_pkg::PS_BIT-1:0]       ps_q;
    logic [dallanma_pkg::VERI_BIT-1:0]     kaynak1_q;
    logic [dallanma_pkg::VERI_BIT-1:0]     kaynak2_q;
    logic [dallanma_pkg::VERI_BIT-1:0]     anlik_q;

    assign yakala = (durum == BOSTA) && islem_req_i;

    always_comb begin
        durum_sonraki = durum;
        case (durum)
            BOSTA: begin
                if (islem_req_i) begin
                    durum_sonraki = COZ;
                end
            end
            COZ: begin
                durum_sonraki = ONAY;
            end
            ONAY: begin
                if (!islem_req_i) begin
                    durum_sonraki = BOSTA;
                end
            end
            default: begin
                durum_sonraki = BOSTA;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            durum <= BOSTA;
        end else begin
            durum <= durum_sonraki;
        end
    end

    // Payload held for the whole handshake
    always_ff @(posedge clk_i) begin
        if (yakala) begin
            kod_q     <= dallanma_pkg::dal_kod_t'(islem_kod_i);
            ps_q      <= islem_ps_i;
            kaynak1_q <= islem_kaynak1_i;
            kaynak2_q <= islem_kaynak2_i;
            anlik_q   <= islem_anlik_i;
        end
    end

    assign sonuc_yaz_o = (durum == COZ);
    assign islem_ack_o = (durum == ONAY);

    assign kod_o     = kod_q;
    assign ps_o      = ps_q;
    assign kaynak1_o = kaynak1_q;
    assign kaynak2_o = kaynak2_q;
    assign anlik_o   = anlik_q;

    // Ack only answers a req sampled two edges earlier
    a_ack_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(islem_ack_o) |-> $past(islem_req_i, 2));

    a_tek_yazma: assert property (@(posedge clk_i) disable iff (reset_i)
        sonuc_yaz_o |=> !sonuc_yaz_o);

endmodule

`default_nettype wire

// File: hdl/karsilastirici.sv
`timescale 1ns/1ps
`default_nettype none

module karsilastirici (
    input  logic [dallanma_pkg::VERI_BIT-1:0] kaynak1_i,
    input  logic [dallanma_pkg::VERI_BIT-1:0] kaynak2_i,

    output logic                             esittir_o,
    output logic                             kucuktur_o,
    output logic                             kucuktur_isaretsiz_o
);

    localparam int MSB = dallanma_pkg::VERI_BIT - 1;

    logic [dallanma_pkg::VERI_BIT:0] fark;  // Extra bit carries the borrow
    logic                            tasma;

    // One subtractor serves all three flags
    assign fark = {1'b0, kaynak1_i} - {1'b0, kaynak2_i};

    // Signed overflow when operand signs differ and result sign flips
    assign tasma = (kaynak1_i[MSB] ^ kaynak2_i[MSB]) & (kaynak1_i[MSB] ^ fark[MSB]);

    assign esittir_o            = (fark[MSB:0] == '0);
    assign kucuktur_o           = fark[MSB] ^ tasma;
    assign kucuktur_isaretsiz_o = fark[dallanma_pkg::VERI_BIT];

endmodule

`default_nettype wire

// File: hdl/tahmin_tablosu.sv
`timescale 1ns/1ps
`default_nettype none

module tahmin_tablosu (
    input  logic                           clk_i,
    input  logic                           reset_i,

    input  logic [dallanma_pkg::PS_BIT-1:0] oku_ps_i,
    output logic                           tahmin_o,

    input  logic                           guncelle_i,
    input  logic [dallanma_pkg::PS_BIT-1:0] yaz_ps_i,
    input  logic                           atladi_i
);

    logic [1:0] sayac [dallanma_pkg::TABLO_BOYUT];

    logic [dallanma_pkg::TABLO_IDX_BIT-1:0] oku_idx;
    logic [dallanma_pkg::TABLO_IDX_BIT-1:0] yaz_idx;
    logic [1:0]                             eski_deger;
    logic [1:0]                             yeni_deger;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 0 is always zero for RV32C addresses
    assign oku_idx  = oku_ps_i[dallanma_pkg::TABLO_IDX_BIT:1];
    assign tahmin_o = sayac[oku_idx][1];    // Upper half means taken

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Training
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign yaz_idx    = yaz_ps_i[dallanma_pkg::TABLO_IDX_BIT:1];
    assign eski_deger = sayac[yaz_idx];

    always_comb begin
        yeni_deger = eski_deger;
        if (atladi_i) begin
            if (eski_deger != 2'd3) begin
                yeni_deger = eski_deger + 2'd1;
            end
        end else begin
            if (eski_deger != 2'd0) begin
                yeni_deger = eski_deger - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < dallanma_pkg::TABLO_BOYUT; i++) begin
                sayac[i] <= dallanma_pkg::SAYAC_BASLANGIC;
            end
        end else if (guncelle_i) begin
            sayac[yaz_idx] <= yeni_deger;
        end
    end

    // Every counter holds a known value once reset has run
    for (genvar g = 0; g < dallanma_pkg::TABLO_BOYUT; g++) begin : g_aralik
        a_sayac_aralik: assert property (@(posedge clk_i) disable iff (reset_i)
            !$isunknown(sayac[g]));
    end

endmodule

`default_nettype wire

// File: sim/dallanma_model.svh
`ifndef DALLANMA_MODEL_SVH
`define DALLANMA_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference counters and resolution rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [1:0] model_sayac [dallanma_pkg::TABLO_BOYUT];

function automatic int tablo_indeksi(input logic [31:0] ps);
    return int'(ps[dallanma_pkg::TABLO_IDX_BIT:1]);
endfunction

function automatic logic dal_mi(input logic [3:0] kod);
    return (kod <= 4'd9);   // Codes 0 to 9 are the ten branch forms
endfunction

function automatic logic kisa_mi(input logic [3:0] kod);
    return (kod == dallanma_pkg::UOP_DAL_CJAL) || (kod == dallanma_pkg::UOP_DAL_CJALR);
endfunction

function automatic logic yazmac_tabanli_mi(input logic [3:0] kod);
    return (kod == dallanma_pkg::UOP_DAL_JALR) || (kod == dallanma_pkg::UOP_DAL_CJALR);
endfunction

// Resolved direction from the raw operands
function automatic logic yon_bul(input logic [3:0] kod, input logic [31:0] a,
                                 input logic [31:0] b);
    case (kod)
        dallanma_pkg::UOP_DAL_BEQ:  return (a == b);
        dallanma_pkg::UOP_DAL_BNE:  return (a != b);
        dallanma_pkg::UOP_DAL_BLT:  return ($signed(a) < $signed(b));
        dallanma_pkg::UOP_DAL_BGE:  return ($signed(a) >= $signed(b));
        dallanma_pkg::UOP_DAL_BLTU: return (a < b);
        dallanma_pkg::UOP_DAL_BGEU: return (a >= b);
        default:                    return dal_mi(kod);   // Jumps always taken
    endcase
endfunction

function automatic logic [31:0] donus_bul(input logic [3:0] kod, input logic [31:0] ps);
    return kisa_mi(kod) ? ps + 32'd2 : ps + 32'd4;
endfunction

function automatic logic [31:0] hedef_bul(input logic [3:0] kod, input logic [31:0] ps,
                                          input logic [31:0] a, input logic [31:0] imm,
                                          input logic yon);
    logic [31:0] hedef;
    if (!yon) begin
        return donus_bul(kod, ps);
    end
    hedef = (yazmac_tabanli_mi(kod) ? a : ps) + imm;
    if (yazmac_tabanli_mi(kod)) begin
        hedef[0] = 1'b0;
    end
    return hedef;
endfunction

task automatic model_sifirla();
    for (int i = 0; i < dallanma_pkg::TABLO_BOYUT; i++) begin
        model_sayac[i] = dallanma_pkg::SAYAC_BASLANGIC;
    end
endtask

// Saturating 2-bit training
task automatic model_egit(input logic [31:0] ps, input logic yon);
    int idx;
    idx = tablo_indeksi(ps);
    if (yon && model_sayac[idx] != 2'd3) begin
        model_sayac[idx] = model_sayac[idx] + 2'd1;
    end else if (!yon && model_sayac[idx] != 2'd0) begin
        model_sayac[idx] = model_sayac[idx] - 2'd1;
    end
endtask

`endif

// File: sim/tb_dallanma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dallanma;

    `include "dallanma_model.svh"

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        islem_req_i;
    logic [3:0]  islem_kod_i;
    logic [31:0] islem_ps_i;
    logic [31:0] islem_kaynak1_i;
    logic [31:0] islem_kaynak2_i;
    logic [31:0] islem_anlik_i;
    logic        islem_ack_o;
    logic [31:0] hedef_ps_o;
    logic        yonlendir_o;
    logic        hatali_tahmin_o;
    logic        atladi_o;
    logic        tahmin_o;
    logic [31:0] donus_ps_o;
    logic        guncelle_o;

    integer seed;
    int     idx_tablo [4] = '{1, 4, 7, 10};   // Few indices so training shows

    always #4 clk_i = ~clk_i;

    dallanma_ust dut (.*);

    task automatic deger_kontrol(input string ad, input logic [31:0] gelen,
                                 input logic [31:0] beklenen);
        assert (gelen === beklenen) else begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", ad, gelen, beklenen);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic kosul_kontrol(input logic kosul, input string mesaj);
        assert (kosul === 1'b1) else begin
            $display("%s", mesaj);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at first failure");
        end
    endtask

    task automatic sonuclari_denetle(input logic e_tahmin, input logic e_atladi,
                                     input logic e_hatali, input logic e_guncelle,
                                     input logic [31:0] e_hedef, input logic [31:0] e_donus);
        deger_kontrol("tahmin_o", tahmin_o, e_tahmin);
        deger_kontrol("atladi_o", atladi_o, e_atladi);
        deger_kontrol("hatali_tahmin_o", hatali_tahmin_o, e_hatali);
        deger_kontrol("yonlendir_o", yonlendir_o, e_hatali);
        deger_kontrol("guncelle_o", guncelle_o, e_guncelle);
        deger_kontrol("donus_ps_o", donus_ps_o, e_donus);
        if (e_hatali) begin
            deger_kontrol("hedef_ps_o", hedef_ps_o, e_hedef);
        end
    endtask

    // One full four-phase handshake, checked against the model
    task automatic islem_yap(input logic [3:0] kod, input logic [31:0] ps,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] imm, input int tut, output logic hatali);
        int          adim;
        logic        gecerli;
        logic        yon;
        logic        e_tahmin;
        logic        e_hatali;
        logic [31:0] e_hedef;
        logic [31:0] e_donus;
        gecerli  = dal_mi(kod);
        yon      = yon_bul(kod, a, b);
        e_tahmin = model_sayac[tablo_indeksi(ps)][1];
        e_hatali = gecerli && (yon != e_tahmin);
        e_hedef  = hedef_bul(kod, ps, a, imm, yon);
        e_donus  = donus_bul(kod, ps);

        @(posedge clk_i);
        islem_req_i     <= 1'b1;
        islem_kod_i     <= kod;
        islem_ps_i      <= ps;
        islem_kaynak1_i <= a;
        islem_kaynak2_i <= b;
        islem_anlik_i   <= imm;

        adim = 0;
        @(negedge clk_i);
        while (islem_ack_o !== 1'b1 && adim < 20) begin
            adim++;
            @(negedge clk_i);
        end
        kosul_kontrol(islem_ack_o, "Timeout: ack did not rise within 20 cycles");
        deger_kontrol("islem_ack_o latency", adim, 2);
        sonuclari_denetle(e_tahmin, yon, e_hatali, gecerli, e_hedef, e_donus);
        hatali = hatali_tahmin_o;

        // Slow source, results must hold while ack stays high
        repeat (tut) begin
            @(negedge clk_i);
            deger_kontrol("islem_ack_o", islem_ack_o, 1'b1);
            sonuclari_denetle(e_tahmin, yon, e_hatali, gecerli, e_hedef, e_donus);
        end

        @(posedge clk_i);
        islem_req_i <= 1'b0;
        adim = 0;
        @(negedge clk_i);
        while (islem_ack_o !== 1'b0 && adim < 20) begin
            adim++;
            @(negedge clk_i);
        end
        kosul_kontrol(!islem_ack_o, "Timeout: ack did not fall within 20 cycles");
        deger_kontrol("islem_ack_o fall cycles", adim, 1);

        if (gecerli) begin
            model_egit(ps, yon);
        end
    endtask

    initial begin
        logic        hatali;
        logic [3:0]  kod;
        logic [31:0] ps;
        logic [31:0] a;
        logic [31:0] b;
        seed            = 31;
        reset_i         = 1'b1;
        islem_req_i     = 1'b0;
        islem_kod_i     = '0;
        islem_ps_i      = '0;
        islem_kaynak1_i = '0;
        islem_kaynak2_i = '0;
        islem_anlik_i   = '0;
        model_sifirla();

        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        deger_kontrol("islem_ack_o", islem_ack_o, 1'b0);
        deger_kontrol("yonlendir_o", yonlendir_o, 1'b0);
        deger_kontrol("hatali_tahmin_o", hatali_tahmin_o, 1'b0);
        deger_kontrol("guncelle_o", guncelle_o, 1'b0);
        deger_kontrol("atladi_o", atladi_o, 1'b0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Directed training at one address
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int i = 0; i < 4; i++) begin
            islem_yap(dallanma_pkg::UOP_DAL_BEQ, 32'h0000_2018, 32'h55, 32'h55, 32'h40, 0, hatali);
            if (i >= 2) begin
                kosul_kontrol(!hatali, "Taken branch still mispredicted after two operations");
            end
        end
        // Counter down to 2, so one stray decrement would flip the next guess
        islem_yap(dallanma_pkg::UOP_DAL_BNE, 32'h0000_2018, 32'h7, 32'h7, 32'h80, 0, hatali);
        islem_yap(4'hC, 32'h0000_2018, 32'h1, 32'h2, 32'h40, 1, hatali);   // Table untouched
        islem_yap(dallanma_pkg::UOP_DAL_BNE, 32'h0000_2018, 32'h7, 32'h7, 32'h80, 0, hatali);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Random operations
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int n = 0; n < 400; n++) begin
            if ($unsigned($random(seed)) % 100 < 85) begin
                kod = 4'($unsigned($random(seed)) % 10);
            end else begin
                kod = 4'(10 + $unsigned($random(seed)) % 6);
            end
            ps      = $random(seed);
            ps[4:1] = 4'(idx_tablo[$unsigned($random(seed)) % 4]);
            ps[0]   = 1'b0;
            a       = $random(seed);
            b       = ($unsigned($random(seed)) % 3 == 0) ? a : $random(seed);
            islem_yap(kod, ps, a, b, $random(seed), $unsigned($random(seed)) % 3, hatali);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
hdl/dallanma_pkg.sv
hdl/islem_girisi.sv
hdl/karsilastirici.sv
hdl/tahmin_tablosu.sv
hdl/dallanma_birimi.sv
hdl/dallanma_ust.sv
sim/tb_dallanma.sv
